// File: source/rp_macros.svh
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

////////////////////////////////////////
// widths
////////////////////////////////////////
`define RP_DATA_W      14        // converter sample width
`define RP_ADC_IN_W    14        // raw adc pins, bits 15:2 of the part
`define RP_BUS_W       32        // system bus word
`define RP_PWM_W       8         // pwm duty width, period is 2**8

// address map
`define RP_N_REGIONS   8
`define RP_REGION_LSB  20        // region field starts here
`define RP_REGION_W    3
`define RP_REG_HK      3'd0      // housekeeping
`define RP_REG_DSP     3'd3      // offset dsp
`define RP_REG_AMS     3'd4      // slow pwm dacs

// response slots on the decoder, one per used region
`define RP_N_USED      3
`define RP_SLOT_HK     0
`define RP_SLOT_DSP    1
`define RP_SLOT_AMS    2

////////////////////////////////////////
// register offsets
////////////////////////////////////////
`define HK_ID          20'h00000
`define HK_LOOP        20'h0000C
`define HK_LED         20'h00030

`define DSP_OFS_A      20'h00000
`define DSP_OFS_B      20'h00004
`define DSP_IN_A       20'h00010
`define DSP_IN_B       20'h00014

`define AMS_PWM_A      20'h00020
`define AMS_PWM_B      20'h00024
`define AMS_PWM_C      20'h00028
`define AMS_PWM_D      20'h0002C

`define RP_HK_ID       32'h5250_0001   // fixed board id word

`endif

// File: source/rp_pkg.sv
`include "rp_macros.svh"

package rp_pkg;

  // two's complement converter sample
  typedef logic signed [`RP_DATA_W-1:0] sample_t;

  ////////////////////////////////////////
  // bus address, two views of one word
  ////////////////////////////////////////
  typedef struct packed {
    logic [`RP_BUS_W-`RP_REGION_W-`RP_REGION_LSB-1:0] unused;  // ignored high bits
    logic [`RP_REGION_W-1:0]                          region;  // picks the slave
    logic [`RP_REGION_LSB-1:0]                        offset;  // register inside slave
  } sys_addr_fields_t;

  typedef union packed {
    logic [`RP_BUS_W-1:0] raw;     // as the master sees it
    sys_addr_fields_t     fields;  // decoder and slave view
  } sys_addr_u;

  // master to slave, strobes are single cycle
  typedef struct packed {
    sys_addr_u            addr;
    logic [`RP_BUS_W-1:0] wdata;
    logic                 wen;
    logic                 ren;
  } sys_req_t;

  // slave to master
  typedef struct packed {
    logic [`RP_BUS_W-1:0] rdata;
    logic                 ack;
  } sys_rsp_t;

endpackage

// File: source/sys_bus_decoder.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module sys_bus_decoder
  import rp_pkg::*;
(
  input  sys_req_t sys_req_i,                     // from the master
  output sys_req_t sys_req_o [`RP_N_REGIONS],     // one copy per region
  input  sys_rsp_t sys_rsp_i [`RP_N_USED],        // hk, dsp, ams in slot order
  output sys_rsp_t sys_rsp_o                      // back to the master
);

  logic [`RP_REGION_W-1:0]  region;
  logic [`RP_N_REGIONS-1:0] region_cs;               // one-hot chip select
  sys_rsp_t                 region_rsp [`RP_N_REGIONS];

  assign region = sys_req_i.addr.fields.region;

  assign region_cs = {{(`RP_N_REGIONS-1){1'b0}}, 1'b1} << region;

  ////////////////////////////////////////
  // request fan-out
  ////////////////////////////////////////
  always_comb
  begin
    for (int r = 0; r < `RP_N_REGIONS; r++)
    begin
      sys_req_o[r]     = sys_req_i;                      // addr and wdata go everywhere
      sys_req_o[r].wen = sys_req_i.wen & region_cs[r];   // strobes only to the selected one
      sys_req_o[r].ren = sys_req_i.ren & region_cs[r];
    end
  end

  ////////////////////////////////////////
  // response collection
  ////////////////////////////////////////
  always_comb
  begin
    // empty regions answer at once with zero
    for (int r = 0; r < `RP_N_REGIONS; r++)
    begin
      region_rsp[r].rdata = '0;
      region_rsp[r].ack   = sys_req_o[r].wen | sys_req_o[r].ren;
    end
    // used regions return their own registered ack
    region_rsp[`RP_REG_HK]  = sys_rsp_i[`RP_SLOT_HK];
    region_rsp[`RP_REG_DSP] = sys_rsp_i[`RP_SLOT_DSP];
    region_rsp[`RP_REG_AMS] = sys_rsp_i[`RP_SLOT_AMS];
  end

  // master holds addr until ack, so mux on the live region field
  assign sys_rsp_o = region_rsp[region];

endmodule

// File: source/housekeeping_regs.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module housekeeping_regs
  import rp_pkg::*;
(
  input  logic       adc_clk,
  input  logic       reset_i,
  input  sys_req_t   sys_req_i,
  output sys_rsp_t   sys_rsp_o,
  output logic [7:0] led_o,
  output logic       digital_loop_o   // dac samples replace adc samples
);

  logic [`RP_REGION_LSB-1:0] ofs;
  logic [`RP_BUS_W-1:0]      rd_mux;   // read value before the register
  logic [`RP_BUS_W-1:0]      rdata_q;
  logic                      ack_q;

  assign ofs = sys_req_i.addr.fields.offset;

  ////////////////////////////////////////
  // control registers
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      led_o          <= '0;
      digital_loop_o <= 1'b0;
    end
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `HK_LOOP: digital_loop_o <= sys_req_i.wdata[0];
        `HK_LED:  led_o          <= sys_req_i.wdata[7:0];
        default:  ;                                        // id is read only
      endcase
    end
  end

  // read decode
  always_comb
  begin
    case (ofs)
      `HK_ID:   rd_mux = `RP_HK_ID;
      `HK_LOOP: rd_mux = {{(`RP_BUS_W-1){1'b0}}, digital_loop_o};
      `HK_LED:  rd_mux = {{(`RP_BUS_W-8){1'b0}}, led_o};
      default:  rd_mux = '0;                               // unmapped reads as zero
    endcase
  end

  ////////////////////////////////////////
  // bus response, one cycle after strobe
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_q <= 1'b0;
    else
      ack_q <= sys_req_i.wen | sys_req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_mux;
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;

endmodule

// File: source/analog_frontend.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module analog_frontend
  import rp_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    reset_i,
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_a_i,    // raw pins, neg slope offset binary
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_b_i,
  input  logic                    digital_loop_i,
  input  sample_t                 dac_a_i,        // from the dsp
  input  sample_t                 dac_b_i,
  output sample_t                 adc_a_o,        // to the dsp
  output sample_t                 adc_b_o,
  output logic [`RP_DATA_W-1:0]   dac_dat_a_o,    // dac pins, same code as adc
  output logic [`RP_DATA_W-1:0]   dac_dat_b_o
);

  // code of a zero sample on the dac pins
  localparam logic [`RP_DATA_W-1:0] DAC_ZERO_CODE = {1'b0, {(`RP_DATA_W-1){1'b1}}};

  logic [`RP_ADC_IN_W-1:0] adc_dat_a;   // input registers
  logic [`RP_ADC_IN_W-1:0] adc_dat_b;

  // neg slope <-> two's complement, same rule both ways
  function automatic logic [`RP_DATA_W-1:0] flip_code(input logic [`RP_DATA_W-1:0] v);
    return {v[`RP_DATA_W-1], ~v[`RP_DATA_W-2:0]};  // keep msb, invert the rest
  endfunction

  ////////////////////////////////////////
  // adc side
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    adc_dat_a <= adc_dat_a_i;
    adc_dat_b <= adc_dat_b_i;
  end

  assign adc_a_o = digital_loop_i ? dac_a_i : sample_t'(flip_code(adc_dat_a));
  assign adc_b_o = digital_loop_i ? dac_b_i : sample_t'(flip_code(adc_dat_b));

  ////////////////////////////////////////
  // dac side
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_dat_a_o <= DAC_ZERO_CODE;    // pins idle at mid scale
      dac_dat_b_o <= DAC_ZERO_CODE;
    end
    else
    begin
      dac_dat_a_o <= flip_code(dac_a_i);
      dac_dat_b_o <= flip_code(dac_b_i);
    end
  end

endmodule

// File: source/channel_offset_dsp.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module channel_offset_dsp
  import rp_pkg::*;
(
  input  logic     adc_clk,
  input  logic     reset_i,
  input  sys_req_t sys_req_i,
  output sys_rsp_t sys_rsp_o,
  input  sample_t  adc_a_i,
  input  sample_t  adc_b_i,
  output sample_t  dac_a_o,    // registered, offset and clipped
  output sample_t  dac_b_o
);

  localparam sample_t S_MAX = {1'b0, {(`RP_DATA_W-1){1'b1}}};  // most positive
  localparam sample_t S_MIN = {1'b1, {(`RP_DATA_W-1){1'b0}}};  // most negative

  logic [`RP_REGION_LSB-1:0] ofs;
  sample_t                   ofs_a;
  sample_t                   ofs_b;
  logic [`RP_BUS_W-1:0]      rd_mux;
  logic [`RP_BUS_W-1:0]      rdata_q;
  logic                      ack_q;

  // add with one guard bit, clip on overflow
  function automatic sample_t sat_add(input sample_t x, input sample_t y);
    logic signed [`RP_DATA_W:0] s;
    s = x + y;
    if (s[`RP_DATA_W] != s[`RP_DATA_W-1])
      return s[`RP_DATA_W] ? S_MIN : S_MAX;   // guard bit holds the true sign
    return s[`RP_DATA_W-1:0];
  endfunction

  function automatic logic [`RP_BUS_W-1:0] sext(input sample_t v);
    return {{(`RP_BUS_W-`RP_DATA_W){v[`RP_DATA_W-1]}}, v};
  endfunction

  assign ofs = sys_req_i.addr.fields.offset;

  ////////////////////////////////////////
  // offset registers
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      ofs_a <= '0;
      ofs_b <= '0;
    end
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `DSP_OFS_A: ofs_a <= sys_req_i.wdata[`RP_DATA_W-1:0];  // low bits only
        `DSP_OFS_B: ofs_b <= sys_req_i.wdata[`RP_DATA_W-1:0];
        default:    ;
      endcase
    end
  end

  // data path register
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      dac_a_o <= '0;
      dac_b_o <= '0;
    end
    else
    begin
      dac_a_o <= sat_add(adc_a_i, ofs_a);
      dac_b_o <= sat_add(adc_b_i, ofs_b);
    end
  end

  ////////////////////////////////////////
  // bus readback
  ////////////////////////////////////////
  always_comb
  begin
    case (ofs)
      `DSP_OFS_A: rd_mux = sext(ofs_a);
      `DSP_OFS_B: rd_mux = sext(ofs_b);
      `DSP_IN_A:  rd_mux = sext(adc_a_i);    // live input sample
      `DSP_IN_B:  rd_mux = sext(adc_b_i);
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_q <= 1'b0;
    else
      ack_q <= sys_req_i.wen | sys_req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_mux;
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;

endmodule

// File: source/pwm_dac_ctrl.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module pwm_dac_ctrl
  import rp_pkg::*;
(
  input  logic       adc_clk,
  input  logic       reset_i,
  input  sys_req_t   sys_req_i,
  output sys_rsp_t   sys_rsp_o,
  output logic [3:0] pwm_o        // slow dacs, filtered off chip
);

  logic [`RP_REGION_LSB-1:0] ofs;
  logic [`RP_PWM_W-1:0]      duty     [4];   // bus side values
  logic [`RP_PWM_W-1:0]      duty_lat [4];   // values in use this period
  logic [`RP_PWM_W-1:0]      cnt;            // shared period counter
  logic                      wrap;
  logic [`RP_BUS_W-1:0]      rd_mux;
  logic [`RP_BUS_W-1:0]      rdata_q;
  logic                      ack_q;

  assign ofs  = sys_req_i.addr.fields.offset;
  assign wrap = &cnt;                         // last count of the period

  ////////////////////////////////////////
  // duty registers
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      for (int k = 0; k < 4; k++)
        duty[k] <= '0;
    end
    else if (sys_req_i.wen)
    begin
      case (ofs)
        `AMS_PWM_A: duty[0] <= sys_req_i.wdata[`RP_PWM_W-1:0];
        `AMS_PWM_B: duty[1] <= sys_req_i.wdata[`RP_PWM_W-1:0];
        `AMS_PWM_C: duty[2] <= sys_req_i.wdata[`RP_PWM_W-1:0];
        `AMS_PWM_D: duty[3] <= sys_req_i.wdata[`RP_PWM_W-1:0];
        default:    ;
      endcase
    end
  end

  ////////////////////////////////////////
  // counter and comparators
  ////////////////////////////////////////
  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
    begin
      cnt   <= '0;
      pwm_o <= '0;
      for (int k = 0; k < 4; k++)
        duty_lat[k] <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;                      // free running, wraps by itself
      for (int k = 0; k < 4; k++)
      begin
        pwm_o[k] <= (cnt < duty_lat[k]);      // duty 0 never high
        if (wrap)
          duty_lat[k] <= duty[k];             // new duty from next period on
      end
    end
  end

  // readback
  always_comb
  begin
    case (ofs)
      `AMS_PWM_A: rd_mux = {{(`RP_BUS_W-`RP_PWM_W){1'b0}}, duty[0]};
      `AMS_PWM_B: rd_mux = {{(`RP_BUS_W-`RP_PWM_W){1'b0}}, duty[1]};
      `AMS_PWM_C: rd_mux = {{(`RP_BUS_W-`RP_PWM_W){1'b0}}, duty[2]};
      `AMS_PWM_D: rd_mux = {{(`RP_BUS_W-`RP_PWM_W){1'b0}}, duty[3]};
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (reset_i)
      ack_q <= 1'b0;
    else
      ack_q <= sys_req_i.wen | sys_req_i.ren;
  end

  always_ff @(posedge adc_clk)
  begin
    if (sys_req_i.ren)
      rdata_q <= rd_mux;
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;

endmodule

// File: source/red_pitaya_core.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module red_pitaya_core
  import rp_pkg::*;
(
  input  logic                    adc_clk,
  input  logic                    reset_i,
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_a_i,   // adc ch1
  input  logic [`RP_ADC_IN_W-1:0] adc_dat_b_i,   // adc ch2
  output logic [`RP_DATA_W-1:0]   dac_dat_a_o,   // dac ch1
  output logic [`RP_DATA_W-1:0]   dac_dat_b_o,   // dac ch2
  output logic [3:0]              dac_pwm_o,     // slow pwm dacs
  output logic [7:0]              led_o,
  input  sys_req_t                sys_req_i,     // system bus
  output sys_rsp_t                sys_rsp_o
);

  sys_req_t region_req [`RP_N_REGIONS];   // gated per region
  sys_rsp_t slot_rsp   [`RP_N_USED];      // hk, dsp, ams
  sample_t  adc_a;
  sample_t  adc_b;
  sample_t  dac_a;
  sample_t  dac_b;
  logic     digital_loop;

  ////////////////////////////////////////
  // bus
  ////////////////////////////////////////
  sys_bus_decoder i_dec (
    .sys_req_i (sys_req_i),
    .sys_req_o (region_req),
    .sys_rsp_i (slot_rsp),
    .sys_rsp_o (sys_rsp_o)
  );

  housekeeping_regs i_hk (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .sys_req_i      (region_req[`RP_REG_HK]),
    .sys_rsp_o      (slot_rsp[`RP_SLOT_HK]),
    .led_o          (led_o),
    .digital_loop_o (digital_loop)
  );

  ////////////////////////////////////////
  // fast analog path
  ////////////////////////////////////////
  analog_frontend i_analog (
    .adc_clk        (adc_clk),
    .reset_i        (reset_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_a_i        (dac_a),
    .dac_b_i        (dac_b),
    .adc_a_o        (adc_a),
    .adc_b_o        (adc_b),
    .dac_dat_a_o    (dac_dat_a_o),
    .dac_dat_b_o    (dac_dat_b_o)
  );

  channel_offset_dsp i_dsp (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .sys_req_i (region_req[`RP_REG_DSP]),
    .sys_rsp_o (slot_rsp[`RP_SLOT_DSP]),
    .adc_a_i   (adc_a),
    .adc_b_i   (adc_b),
    .dac_a_o   (dac_a),
    .dac_b_o   (dac_b)
  );

  // slow dacs in the ams region
  pwm_dac_ctrl i_pwm (
    .adc_clk   (adc_clk),
    .reset_i   (reset_i),
    .sys_req_i (region_req[`RP_REG_AMS]),
    .sys_rsp_o (slot_rsp[`RP_SLOT_AMS]),
    .pwm_o     (dac_pwm_o)
  );

endmodule

// File: verif/rp_core_tb.sv
`timescale 1ns/10ps
`include "rp_macros.svh"

module rp_core_tb
  import rp_pkg::*;
();

  localparam int S_MAX       = (1 << (`RP_DATA_W-1)) - 1;   // most positive sample
  localparam int S_MIN       = -(1 << (`RP_DATA_W-1));      // most negative sample
  localparam int PWM_PERIOD  = 1 << `RP_PWM_W;
  localparam int ACK_WAIT    = 4;                           // cycles before a missing ack
  localparam int XFER_CYC    = 4;                           // worst case per transfer
  localparam int N_XFERS     = 80;
  localparam int DP_ROUNDS   = 5;
  localparam int DP_SAMPLES  = 48;
  localparam int RB_COUNT    = 6;
  localparam int LOOP_CYCLES = 272;                         // full swing at the smallest step
  localparam int PWM_SETTLE  = PWM_PERIOD + 4;
  localparam int PWM_WINDOWS = 2;
  localparam int TEST_CYCLES = 8 + N_XFERS * XFER_CYC + DP_ROUNDS * (DP_SAMPLES + 4)
                               + RB_COUNT * 2 + LOOP_CYCLES + PWM_SETTLE
                               + PWM_WINDOWS * PWM_PERIOD;
  localparam int CYCLE_LIMIT = TEST_CYCLES + TEST_CYCLES / 4;

  logic                    adc_clk;
  logic                    reset_i;
  logic [`RP_ADC_IN_W-1:0] adc_dat_a;
  logic [`RP_ADC_IN_W-1:0] adc_dat_b;
  logic [`RP_DATA_W-1:0]   dac_dat_a;
  logic [`RP_DATA_W-1:0]   dac_dat_b;
  logic [3:0]              dac_pwm;
  logic [7:0]              led;
  sys_req_t                bus_req;
  sys_rsp_t                bus_rsp;

  logic [31:0]           rng;                 // lcg state
  int                    mismatch_cnt;
  int                    fail_cnt;
  int                    dp_mismatch_cnt;     // owned by the checking process
  int                    cycle_cnt;
  logic                  dp_check_en;
  int                    ofs_a_model;         // offsets as the dsp should hold them
  int                    ofs_b_model;
  logic [`RP_DATA_W-1:0] exp_a_q [$];         // expected dac codes in flight
  logic [`RP_DATA_W-1:0] exp_b_q [$];
  logic [`RP_DATA_W-1:0] exp_a;
  logic [`RP_DATA_W-1:0] exp_b;

  red_pitaya_core dut (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_dat_a_o (dac_dat_a),
    .dac_dat_b_o (dac_dat_b),
    .dac_pwm_o   (dac_pwm),
    .led_o       (led),
    .sys_req_i   (bus_req),
    .sys_rsp_o   (bus_rsp)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;   // 250 MHz
  end

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // neg slope offset binary with code 0 at full positive
  function automatic int code_to_sample(input logic [`RP_DATA_W-1:0] code);
    return S_MAX - int'(code);
  endfunction

  function automatic logic [`RP_DATA_W-1:0] sample_to_code(input int v);
    int t;
    t = S_MAX - v;
    return t[`RP_DATA_W-1:0];
  endfunction

  function automatic int clip_sum(input int x, input int y);
    int s;
    s = x + y;
    if (s > S_MAX)
      return S_MAX;
    if (s < S_MIN)
      return S_MIN;
    return s;
  endfunction

  // high cycles of one pwm period for a duty
  function automatic int pwm_high_count(input int duty);
    int n;
    n = 0;
    for (int c = 0; c < PWM_PERIOD; c++)
      if (c < duty)
        n++;
    return n;
  endfunction

  function automatic logic [31:0] make_addr(input logic [`RP_REGION_W-1:0] region,
                                            input logic [`RP_REGION_LSB-1:0] ofs);
    return {{(`RP_BUS_W-`RP_REGION_W-`RP_REGION_LSB){1'b0}}, region, ofs};
  endfunction

  task automatic report_mismatch(input string test, input logic [31:0] exp,
                                 input logic [31:0] act);
    mismatch_cnt++;
    $display("mismatch %s: expected %h, actual %h", test, exp, act);
  endtask

  ////////////////////////////////////////
  // bus master
  ////////////////////////////////////////
  task automatic bus_xfer(input logic [31:0] addr, input logic [31:0] wdata,
                          input logic write, output logic [31:0] rdata, output int lat);
    @(posedge adc_clk);
    bus_req.addr.raw <= addr;     // held until ack
    bus_req.wdata    <= wdata;
    bus_req.wen      <= write;
    bus_req.ren      <= ~write;
    lat = 0;
    @(negedge adc_clk);
    while (!bus_rsp.ack && lat < ACK_WAIT)
    begin
      @(posedge adc_clk);
      bus_req.wen <= 1'b0;        // single cycle strobe
      bus_req.ren <= 1'b0;
      lat++;
      @(negedge adc_clk);
    end
    rdata = bus_rsp.rdata;
    if (!bus_rsp.ack)
    begin
      fail_cnt++;
      $display("no bus ack from address %h within %0d cycles", addr, ACK_WAIT);
    end
    @(posedge adc_clk);
    bus_req.wen <= 1'b0;
    bus_req.ren <= 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] unused_rd;
    int          lat;
    bus_xfer(addr, wdata, 1'b1, unused_rd, lat);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
    int lat;
    bus_xfer(addr, '0, 1'b0, rdata, lat);
  endtask

  ////////////////////////////////////////
  // data path checker over a 3 deep pipe
  ////////////////////////////////////////
  always @(negedge adc_clk)
  begin
    if (dp_check_en)
    begin
      if (exp_a_q.size() == 3)
      begin
        exp_a = exp_a_q.pop_front();
        exp_b = exp_b_q.pop_front();
        if (dac_dat_a !== exp_a)
        begin
          dp_mismatch_cnt++;
          $display("mismatch datapath a: expected %h, actual %h", exp_a, dac_dat_a);
        end
        if (dac_dat_b !== exp_b)
        begin
          dp_mismatch_cnt++;
          $display("mismatch datapath b: expected %h, actual %h", exp_b, dac_dat_b);
        end
      end
      exp_a_q.push_back(sample_to_code(clip_sum(code_to_sample(adc_dat_a), ofs_a_model)));
      exp_b_q.push_back(sample_to_code(clip_sum(code_to_sample(adc_dat_b), ofs_b_model)));
    end
    else
    begin
      exp_a_q.delete();   // nothing in flight outside a window
      exp_b_q.delete();
    end
  end

  // run length guard
  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT)
    begin
      @(posedge adc_clk);
      cycle_cnt++;
    end
    $display("timeout, tests still running after %0d cycles", cycle_cnt);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////
  initial
  begin
    logic [31:0]             rd;
    logic [7:0]              led_val;
    logic [`RP_REGION_W-1:0] reg_sel;
    int                      lat;
    int                      exp_lat;
    int                      ka;
    int                      kb;
    int                      prev_a;
    int                      prev_b;
    int                      cur_a;
    int                      cur_b;
    int                      duty [4];
    int                      hi_cnt [4];

    rng             = 32'h4dca;
    mismatch_cnt    = 0;
    fail_cnt        = 0;
    dp_mismatch_cnt = 0;
    dp_check_en     = 1'b0;
    ofs_a_model     = 0;
    ofs_b_model     = 0;
    reset_i         = 1'b1;
    adc_dat_a       = 14'h1FFF;   // zero code
    adc_dat_b       = 14'h1FFF;
    bus_req         = '0;

    repeat (8) @(posedge adc_clk);
    reset_i <= 1'b0;
    @(negedge adc_clk);
    if (dac_dat_a !== sample_to_code(0))
      report_mismatch("reset dac a", sample_to_code(0), dac_dat_a);
    if (dac_dat_b !== sample_to_code(0))
      report_mismatch("reset dac b", sample_to_code(0), dac_dat_b);
    if (led !== 8'h00) report_mismatch("reset led", 0, led);
    if (dac_pwm !== 4'h0) report_mismatch("reset pwm", 0, dac_pwm);
    if (bus_rsp.ack !== 1'b0) report_mismatch("reset ack", 0, bus_rsp.ack);

    // housekeeping
    bus_read(make_addr(`RP_REG_HK, `HK_ID), rd);
    if (rd !== `RP_HK_ID) report_mismatch("hk id", `RP_HK_ID, rd);
    rng = lcg(rng);
    led_val = rng[31:24];
    bus_write(make_addr(`RP_REG_HK, `HK_LED), {24'h0, led_val});
    @(negedge adc_clk);
    if (led !== led_val) report_mismatch("hk led pins", led_val, led);
    bus_read(make_addr(`RP_REG_HK, `HK_LED), rd);
    if (rd !== {24'h0, led_val}) report_mismatch("hk led read", led_val, rd);
    bus_write(make_addr(`RP_REG_HK, `HK_ID), ~`RP_HK_ID);   // read only
    bus_read(make_addr(`RP_REG_HK, `HK_ID), rd);
    if (rd !== `RP_HK_ID) report_mismatch("hk id after write", `RP_HK_ID, rd);
    bus_write(make_addr(`RP_REG_HK, `HK_LOOP), 32'h1);
    bus_read(make_addr(`RP_REG_HK, `HK_LOOP), rd);
    if (rd !== 32'h1) report_mismatch("hk loop read", 1, rd);
    bus_write(make_addr(`RP_REG_HK, `HK_LOOP), 32'h0);

    // ack timing per region
    for (int r = 0; r < `RP_N_REGIONS; r++)
    begin
      reg_sel = r[`RP_REGION_W-1:0];
      rng     = lcg(rng);
      exp_lat = (reg_sel == `RP_REG_HK || reg_sel == `RP_REG_DSP ||
                 reg_sel == `RP_REG_AMS) ? 1 : 0;   // used ones are registered
      bus_xfer(make_addr(reg_sel, {rng[31:16], 4'h0}), '0, 1'b0, rd, lat);
      if (lat != exp_lat) report_mismatch($sformatf("region %0d latency", r), exp_lat, lat);
      if (exp_lat == 0 && rd !== 32'h0)
        report_mismatch($sformatf("region %0d rdata", r), 0, rd);
    end
    bus_read(make_addr(`RP_REG_AMS, 20'h00000), rd);        // unmapped offset
    if (rd !== 32'h0) report_mismatch("ams unmapped", 0, rd);

    ////////////////////////////////////////
    // data path with offsets
    ////////////////////////////////////////
    for (int r = 0; r < DP_ROUNDS; r++)
    begin
      rng = lcg(rng);
      case (r)
        0:
        begin
          ofs_a_model = 0;
          ofs_b_model = 0;
        end
        1:
        begin
          ofs_a_model = S_MAX;   // pushes both rails
          ofs_b_model = S_MIN;
        end
        2:
        begin
          ofs_a_model = S_MIN;
          ofs_b_model = S_MAX;
        end
        default:
        begin
          ofs_a_model = $signed(rng[31:18]);
          ofs_b_model = $signed(rng[17:4]);
        end
      endcase
      bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_A), ofs_a_model);
      bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_B), ofs_b_model);
      bus_read(make_addr(`RP_REG_DSP, `DSP_OFS_A), rd);
      if (rd !== ofs_a_model) report_mismatch("dsp ofs a read", ofs_a_model, rd);
      bus_read(make_addr(`RP_REG_DSP, `DSP_OFS_B), rd);
      if (rd !== ofs_b_model) report_mismatch("dsp ofs b read", ofs_b_model, rd);
      dp_check_en = 1'b1;
      for (int s = 0; s < DP_SAMPLES; s++)
      begin
        @(posedge adc_clk);
        rng = lcg(rng);
        adc_dat_a <= rng[31:18];
        adc_dat_b <= rng[17:4];
      end
      repeat (4) @(posedge adc_clk);   // let the last samples drain
      dp_check_en = 1'b0;
    end

    // input readback with the pins held
    for (int i = 0; i < RB_COUNT; i++)
    begin
      @(posedge adc_clk);
      rng = lcg(rng);
      adc_dat_a <= rng[31:18];
      adc_dat_b <= rng[17:4];
      bus_read(make_addr(`RP_REG_DSP, `DSP_IN_A), rd);
      if (rd !== code_to_sample(rng[31:18]))
        report_mismatch("dsp in a", code_to_sample(rng[31:18]), rd);
      bus_read(make_addr(`RP_REG_DSP, `DSP_IN_B), rd);
      if (rd !== code_to_sample(rng[17:4]))
        report_mismatch("dsp in b", code_to_sample(rng[17:4]), rd);
    end

    ////////////////////////////////////////
    // loopback ramps
    ////////////////////////////////////////
    rng = lcg(rng);
    ka  = 64 + int'(rng[31:25]);      // a climbs
    kb  = -(64 + int'(rng[24:18]));   // b falls
    bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_A), ka);
    bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_B), kb);
    bus_write(make_addr(`RP_REG_HK, `HK_LOOP), 32'h1);
    @(negedge adc_clk);
    prev_a = code_to_sample(dac_dat_a);
    prev_b = code_to_sample(dac_dat_b);
    repeat (LOOP_CYCLES)
    begin
      @(negedge adc_clk);
      cur_a = code_to_sample(dac_dat_a);
      cur_b = code_to_sample(dac_dat_b);
      if (cur_a != clip_sum(prev_a, ka))
        report_mismatch("loopback a", clip_sum(prev_a, ka), cur_a);
      if (cur_b != clip_sum(prev_b, kb))
        report_mismatch("loopback b", clip_sum(prev_b, kb), cur_b);
      prev_a = cur_a;
      prev_b = cur_b;
    end
    if (prev_a != S_MAX) report_mismatch("loopback a rail", S_MAX, prev_a);
    if (prev_b != S_MIN) report_mismatch("loopback b rail", S_MIN, prev_b);
    bus_write(make_addr(`RP_REG_HK, `HK_LOOP), 32'h0);
    bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_A), 32'h0);
    bus_write(make_addr(`RP_REG_DSP, `DSP_OFS_B), 32'h0);

    ////////////////////////////////////////
    // pwm duty
    ////////////////////////////////////////
    rng     = lcg(rng);
    duty[0] = 0;                               // must stay low
    duty[1] = PWM_PERIOD - 1;
    duty[2] = 1 + int'(rng[31:24]) % (PWM_PERIOD - 2);
    duty[3] = int'(rng[15:8]);
    for (int k = 0; k < 4; k++)
      bus_write(make_addr(`RP_REG_AMS, `AMS_PWM_A + 4 * k), duty[k]);
    for (int k = 0; k < 4; k++)
    begin
      bus_read(make_addr(`RP_REG_AMS, `AMS_PWM_A + 4 * k), rd);
      if (rd !== duty[k]) report_mismatch($sformatf("pwm %0d read", k), duty[k], rd);
    end
    repeat (PWM_SETTLE) @(posedge adc_clk);   // past the next wrap
    for (int w = 0; w < PWM_WINDOWS; w++)
    begin
      for (int k = 0; k < 4; k++)
        hi_cnt[k] = 0;
      repeat (PWM_PERIOD)
      begin
        @(negedge adc_clk);
        for (int k = 0; k < 4; k++)
          if (dac_pwm[k])
            hi_cnt[k]++;
      end
      for (int k = 0; k < 4; k++)
        if (hi_cnt[k] != pwm_high_count(duty[k]))
          report_mismatch($sformatf("pwm %0d high count", k), pwm_high_count(duty[k]),
                          hi_cnt[k]);
    end

    $display("mismatches: %0d, other failures: %0d", mismatch_cnt + dp_mismatch_cnt,
             fail_cnt);
    if (mismatch_cnt + dp_mismatch_cnt + fail_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// File: rp_core.f
+incdir+source
source/rp_pkg.sv
source/sys_bus_decoder.sv
source/housekeeping_regs.sv
source/analog_frontend.sv
source/channel_offset_dsp.sv
source/pwm_dac_ctrl.sv
source/red_pitaya_core.sv
verif/rp_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rp_core testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module rp_core_tb -f rp_core.f -o rp_core_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/rp_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

exit 0
